//--- tb.f
common/mmio_pkg.sv
ep_out/mmio_cmd_parser.sv
ep_out/packet_fifo.sv
logic/mmio_store_unit.sv
logic/mmio_ep_top.sv
dv/tb_mmio_ep.sv

//--- Bender.yml
package:
  name: mmio_ep

sources:
  - files:
      - common/mmio_pkg.sv
      - ep_out/mmio_cmd_parser.sv
      - ep_out/packet_fifo.sv
      - logic/mmio_store_unit.sv
      - logic/mmio_ep_top.sv
  - target: simulation
    files:
      - dv/tb_mmio_ep.sv

//--- dv/tb_mmio_ep.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mmio_ep;

  localparam int FIFO_DEPTH  = 4;
  localparam int REG_WORDS   = 16;
  localparam int RA_W        = $clog2(REG_WORDS);
  localparam int N_SET       = 8;
  localparam int N_STORE     = 12;
  localparam int MAX_LEN     = 40;
  localparam int FRAME_BYTES = 11;
  // Upper bound on bytes sent by SET and STORE groups, back-pressure pair and stall cases
  localparam int BYTE_BUDGET = N_SET * FRAME_BYTES + (N_STORE + 2) * (FRAME_BYTES + MAX_LEN) +
                               8 * FRAME_BYTES;
  localparam int TIMEOUT_CYCLES = 20 * BYTE_BUDGET + 2000;
  localparam logic [31:0] SEED  = 32'hd1a82b4d;

  logic                 clock;
  logic                 rst_n;
  logic                 usb_valid;
  logic                 usb_ready_o;
  logic [7:0]           usb_data;
  logic                 usb_last;
  logic                 resp_valid_o;
  logic                 resp_ready;
  mmio_pkg::mmio_resp_t resp;
  logic                 stalled_o;
  logic                 clear_stall;
  logic [RA_W-1:0]      rd_addr;
  logic [31:0]          rd_data_o;

  // Reference register space and expected responses in command order
  logic [31:0] ref_regs [REG_WORDS];
  logic [5:0]  exp_q [$];
  logic [7:0]  payload [$];
  logic [31:0] stim_lfsr;
  logic [31:0] resp_lfsr;
  // Forces resp_ready low for the back-pressure test
  logic        resp_hold;
  int          bytes_sent;
  int          cycle_count;
  string       test_name;

  mmio_ep_top #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .REG_WORDS (REG_WORDS)
  ) dut_i (
    .clock        (clock),
    .rst_n_i      (rst_n),
    .usb_valid_i  (usb_valid),
    .usb_ready_o  (usb_ready_o),
    .usb_data_i   (usb_data),
    .usb_last_i   (usb_last),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready),
    .resp_o       (resp),
    .stalled_o    (stalled_o),
    .clear_stall_i(clear_stall),
    .rd_addr_i    (rd_addr),
    .rd_data_o    (rd_data_o)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] galois_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], stim_lfsr[0]};
      stim_lfsr = galois_step(stim_lfsr);
    end
    return val;
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  function automatic string mismatch_line(input string what, input logic [31:0] exp,
                                          input logic [31:0] act);
    return $sformatf("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
  endfunction

  // Expected effect of one command
  // STORE bytes go to lane idx%4 of word idx/4
  // idx wraps over the 4*REG_WORDS byte space
  function automatic void ref_apply(input logic [3:0] tag, input logic [1:0] op,
                                    input logic [27:0] addr, input logic [15:0] len);
    int idx;
    if (op == 2'd1) begin
      ref_regs[(addr >> 2) % REG_WORDS] = {16'h0000, len};
    end else begin
      for (int i = 0; i < len; i++) begin
        idx = (addr + i) % (4 * REG_WORDS);
        ref_regs[idx / 4][8 * (idx % 4) +: 8] = payload[i];
      end
    end
    exp_q.push_back({tag, op});
  endfunction

  // Called at a falling edge and returns at the falling edge after the byte is taken
  task automatic send_byte(input logic [7:0] b, input logic last);
    logic [31:0] gap;
    logic        accepted;
    gap = rand_bits(2);
    repeat (gap) @(negedge clock);
    usb_valid = 1'b1;
    usb_data  = b;
    usb_last  = last;
    accepted  = 1'b0;
    // Ready does not depend on valid, so it holds until the rising edge
    while (!accepted) begin
      accepted = usb_ready_o;
      @(negedge clock);
    end
    usb_valid = 1'b0;
    usb_last  = 1'b0;
    bytes_sent++;
  endtask

  // First nbytes of a frame with the last flag on byte last_at (0 for none)
  task automatic send_frame(input logic [27:0] addr, input logic [3:0] lun,
                            input logic [15:0] len, input logic [7:0] idop,
                            input int nbytes, input int last_at);
    logic [7:0] fb [11];
    // Magic "TART" sent first character first
    fb[0]  = 8'h54;
    fb[1]  = 8'h41;
    fb[2]  = 8'h52;
    fb[3]  = 8'h54;
    fb[4]  = addr[7:0];
    fb[5]  = addr[15:8];
    fb[6]  = addr[23:16];
    fb[7]  = {lun, addr[27:24]};
    fb[8]  = len[7:0];
    fb[9]  = len[15:8];
    fb[10] = idop;
    for (int i = 0; i < nbytes; i++) begin
      send_byte(fb[i], (i + 1) == last_at);
    end
  endtask

  task automatic send_set(input logic [27:0] addr, input logic [15:0] value,
                          input logic [3:0] tag);
    logic [3:0] lun;
    lun = rand_bits(4);
    ref_apply(tag, mmio_pkg::OP_SET, addr, value);
    send_frame(addr, lun, value, {tag, 2'b00, mmio_pkg::OP_SET}, FRAME_BYTES, FRAME_BYTES);
  endtask

  task automatic send_store(input logic [27:0] addr, input logic [15:0] len,
                            input logic [3:0] tag);
    logic [3:0] lun;
    lun = rand_bits(4);
    payload.delete();
    for (int i = 0; i < len; i++) begin
      payload.push_back(rand_bits(8));
    end
    ref_apply(tag, mmio_pkg::OP_STORE, addr, len);
    send_frame(addr, lun, len, {tag, 2'b00, mmio_pkg::OP_STORE}, FRAME_BYTES, FRAME_BYTES);
    for (int i = 0; i < len; i++) begin
      send_byte(payload[i], (i + 1) == len);
    end
  endtask

  // All responses seen plus a little slack
  task automatic wait_idle();
    while (exp_q.size() != 0) begin
      @(negedge clock);
    end
    repeat (2) @(negedge clock);
  endtask

  // Whole register space against the reference
  task automatic check_regs();
    for (int w = 0; w < REG_WORDS; w++) begin
      @(negedge clock);
      rd_addr = RA_W'(w);
      #2;
      assert (rd_data_o == ref_regs[w])
        else stop_with_failure(mismatch_line($sformatf("word %0d", w), ref_regs[w], rd_data_o));
    end
    @(negedge clock);
  endtask

  // Stall held and then cleared with no register change
  task automatic expect_stall();
    repeat (4) begin
      assert ({stalled_o, usb_ready_o, resp_valid_o} == 3'b100)
        else stop_with_failure(mismatch_line("stall status",
                                             3'b100, {stalled_o, usb_ready_o, resp_valid_o}));
      @(negedge clock);
    end
    clear_stall = 1'b1;
    @(negedge clock);
    clear_stall = 1'b0;
    assert ({stalled_o, usb_ready_o} == 2'b01)
      else stop_with_failure(mismatch_line("status after clear", 2'b01, {stalled_o, usb_ready_o}));
    check_regs();
  endtask

  // Random response ready and a compare on each handshake
  always @(negedge clock) begin : resp_side
    logic [5:0] exp_resp;
    resp_ready = !resp_hold && resp_lfsr[0];
    resp_lfsr  = galois_step(resp_lfsr);
    // Handshake completes at the next rising edge
    if (resp_valid_o && resp_ready) begin
      assert (exp_q.size() != 0)
        else stop_with_failure($sformatf("%s: response with no command outstanding", test_name));
      exp_resp = exp_q.pop_front();
      assert (resp == exp_resp)
        else stop_with_failure(mismatch_line("response tag/op", exp_resp, resp));
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      stop_with_failure($sformatf("Timeout: no completion within %0d cycles in test %s",
                                  TIMEOUT_CYCLES, test_name));
    end
  end

  initial begin : stimulus
    logic [27:0] addr;
    logic [15:0] len;
    logic [3:0]  tag;
    int          base;
    usb_valid   = 1'b0;
    usb_data    = 8'h00;
    usb_last    = 1'b0;
    resp_ready  = 1'b0;
    clear_stall = 1'b0;
    rd_addr     = '0;
    rst_n       = 1'b0;
    resp_hold   = 1'b0;
    stim_lfsr   = SEED;
    resp_lfsr   = SEED;
    bytes_sent  = 0;
    cycle_count = 0;
    test_name   = "reset";
    for (int i = 0; i < REG_WORDS; i++) begin
      ref_regs[i] = 32'h0;
    end
    repeat (8) @(negedge clock);
    rst_n = 1'b1;
    @(negedge clock);

    assert ({usb_ready_o, resp_valid_o, stalled_o} == 3'b100)
      else stop_with_failure(mismatch_line("status after reset",
                                           3'b100, {usb_ready_o, resp_valid_o, stalled_o}));
    check_regs();

    // Random SET commands
    test_name = "set";
    for (int i = 0; i < N_SET; i++) begin
      addr = rand_bits(28);
      len  = rand_bits(16);
      tag  = rand_bits(4);
      send_set(addr, len, tag);
    end
    wait_idle();
    check_regs();

    // STORE with zero length first and a wrapping unaligned one second
    test_name = "store";
    for (int i = 0; i < N_STORE; i++) begin
      addr = rand_bits(28);
      len  = rand_bits(6) % (MAX_LEN + 1);
      tag  = rand_bits(4);
      if (i == 0) begin
        len = 16'd0;
      end else if (i == 1) begin
        addr = 28'h000003a;
        len  = 16'd40;
      end
      send_store(addr, len, tag);
    end
    wait_idle();
    check_regs();

    // Input must stop after the first command while the response is held
    test_name = "backpressure";
    resp_hold = 1'b1;
    base      = bytes_sent;
    fork
      begin
        send_store(28'h00000a1, 16'd16, 4'h7);
        send_set(28'h0000004, 16'hbeef, 4'h8);
      end
      begin
        repeat (200) @(negedge clock);
        #2;
        assert (bytes_sent - base == FRAME_BYTES + 16)
          else stop_with_failure(mismatch_line("bytes accepted",
                                               FRAME_BYTES + 16, bytes_sent - base));
        assert ({usb_ready_o, resp_valid_o} == 2'b01)
          else stop_with_failure(mismatch_line("ready/resp_valid while held",
                                               2'b01, {usb_ready_o, resp_valid_o}));
        resp_hold = 1'b0;
      end
    join
    wait_idle();
    check_regs();

    // Malformed frames each followed by a good SET
    test_name = "stall_bad_magic";
    send_byte(8'h54, 1'b0);
    send_byte(8'h58, 1'b0);
    expect_stall();
    send_set(28'h0000010, 16'h1234, 4'h1);
    wait_idle();
    check_regs();

    test_name = "stall_early_last";
    send_frame(28'h0000020, 4'h0, 16'h5555, 8'h21, 6, 6);
    expect_stall();
    send_set(28'h0000024, 16'h2345, 4'h2);
    wait_idle();
    check_regs();

    test_name = "stall_missing_last";
    send_frame(28'h0000028, 4'h0, 16'h6666, 8'h31, FRAME_BYTES, 0);
    expect_stall();
    send_set(28'h000002c, 16'h3456, 4'h3);
    wait_idle();
    check_regs();

    test_name = "stall_reserved_op";
    send_frame(28'h0000030, 4'h0, 16'h7777, 8'h43, FRAME_BYTES, FRAME_BYTES);
    expect_stall();
    send_set(28'h0000034, 16'h4567, 4'h4);
    wait_idle();
    check_regs();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/mmio_ep_top.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_ep_top #(
  parameter int FIFO_DEPTH = 16,
  parameter int REG_WORDS  = 16
) (
  input  logic                         clock,
  input  logic                         rst_n_i,
  // Bulk-Out byte stream
  input  logic                         usb_valid_i,
  output logic                         usb_ready_o,
  input  logic [7:0]                   usb_data_i,
  input  logic                         usb_last_i,
  // Responses
  output logic                         resp_valid_o,
  input  logic                         resp_ready_i,
  output mmio_pkg::mmio_resp_t         resp_o,
  // Stall status and host clear
  output logic                         stalled_o,
  input  logic                         clear_stall_i,
  // Register read port
  input  logic [$clog2(REG_WORDS)-1:0] rd_addr_i,
  output logic [31:0]                  rd_data_o
);

  // Parser to store unit
  logic                   cmd_valid;
  logic                   cmd_ready;
  mmio_pkg::mmio_cmd_t    cmd;
  logic                   done;
  // Parser to FIFO
  logic                   in_valid;
  logic                   in_ready;
  mmio_pkg::stream_beat_t in_beat;
  // FIFO to store unit
  logic                   out_valid;
  logic                   out_ready;
  mmio_pkg::stream_beat_t out_beat;

  mmio_cmd_parser parser_i (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .usb_valid_i  (usb_valid_i),
    .usb_ready_o  (usb_ready_o),
    .usb_data_i   (usb_data_i),
    .usb_last_i   (usb_last_i),
    .cmd_valid_o  (cmd_valid),
    .cmd_ready_i  (cmd_ready),
    .cmd_o        (cmd),
    .fifo_valid_o (in_valid),
    .fifo_ready_i (in_ready),
    .fifo_beat_o  (in_beat),
    .done_i       (done),
    .clear_stall_i(clear_stall_i),
    .stalled_o    (stalled_o)
  );

  // Holds STORE payload ahead of the store unit
  packet_fifo #(
    .DEPTH(FIFO_DEPTH)
  ) fifo_i (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .in_valid_i (in_valid),
    .in_ready_o (in_ready),
    .in_beat_i  (in_beat),
    .out_valid_o(out_valid),
    .out_ready_i(out_ready),
    .out_beat_o (out_beat)
  );

  mmio_store_unit #(
    .REG_WORDS(REG_WORDS)
  ) store_i (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .cmd_valid_i (cmd_valid),
    .cmd_ready_o (cmd_ready),
    .cmd_i       (cmd),
    .data_valid_i(out_valid),
    .data_ready_o(out_ready),
    .data_beat_i (out_beat),
    .resp_valid_o(resp_valid_o),
    .resp_ready_i(resp_ready_i),
    .resp_o      (resp_o),
    .done_o      (done),
    .rd_addr_i   (rd_addr_i),
    .rd_data_o   (rd_data_o)
  );

endmodule

`default_nettype wire

//--- logic/mmio_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_store_unit #(
  parameter int REG_WORDS = 16
) (
  input  logic                         clock,
  input  logic                         rst_n_i,
  // Command from the parser
  input  logic                         cmd_valid_i,
  output logic                         cmd_ready_o,
  input  mmio_pkg::mmio_cmd_t          cmd_i,
  // STORE payload from the packet FIFO
  input  logic                         data_valid_i,
  output logic                         data_ready_o,
  input  mmio_pkg::stream_beat_t       data_beat_i,
  // Tagged response
  output logic                         resp_valid_o,
  input  logic                         resp_ready_i,
  output mmio_pkg::mmio_resp_t         resp_o,
  output logic                         done_o,
  // Bus-side read port
  input  logic [$clog2(REG_WORDS)-1:0] rd_addr_i,
  output logic [31:0]                  rd_data_o
);

  localparam int AW = $clog2(REG_WORDS);

  typedef enum logic [1:0] {
    IDLE,
    STORE,
    RESP
  } state_e;

  state_e               state_q;
  logic [31:0]          regs_q [REG_WORDS];
  // Running byte address, wraps inside the register array
  logic [AW+1:0]        baddr_q;
  mmio_pkg::mmio_resp_t resp_q;
  logic                 cmd_take;
  logic                 data_take;
  logic [AW-1:0]        set_word;

  assign cmd_ready_o  = (state_q == IDLE);
  assign data_ready_o = (state_q == STORE);
  assign resp_valid_o = (state_q == RESP);
  assign resp_o       = resp_q;
  // Completion seen by the parser on the response handshake
  assign done_o       = resp_valid_o && resp_ready_i;
  assign rd_data_o    = regs_q[rd_addr_i];

  assign cmd_take  = cmd_valid_i && cmd_ready_o;
  assign data_take = data_valid_i && data_ready_o;
  assign set_word  = cmd_i.addr[AW+1:2];

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          // Zero-length STORE responds at once, like SET
          if (cmd_take) begin
            if (cmd_i.op == mmio_pkg::OP_STORE && cmd_i.len != 16'd0) begin
              state_q <= STORE;
            end else begin
              state_q <= RESP;
            end
          end
        end
        STORE: begin
          if (data_take && data_beat_i.last) begin
            state_q <= RESP;
          end
        end
        RESP: begin
          if (resp_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Command context
  // LUN has no effect on a single-unit register space
  always_ff @(posedge clock) begin
    if (cmd_take) begin
      resp_q  <= '{tag: cmd_i.tag, op: cmd_i.op};
      baddr_q <= cmd_i.addr[AW+1:0];
    end else if (data_take) begin
      baddr_q <= baddr_q + 1'b1;
    end
  end

  // Register space
  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < REG_WORDS; i++) begin
        regs_q[i] <= 32'h0;
      end
    end else if (cmd_take && cmd_i.op == mmio_pkg::OP_SET) begin
      regs_q[set_word] <= {16'h0000, cmd_i.len};
    end else if (data_take) begin
      // One byte lane per popped beat
      regs_q[baddr_q[AW+1:2]][8*baddr_q[1:0] +: 8] <= data_beat_i.data;
    end
  end

endmodule

`default_nettype wire

//--- ep_out/packet_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module packet_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                   clock,
  input  logic                   rst_n_i,
  // Write side
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  mmio_pkg::stream_beat_t in_beat_i,
  // Read side, first word falls through
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output mmio_pkg::stream_beat_t out_beat_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  mmio_pkg::stream_beat_t mem_q [DEPTH];
  logic [AW-1:0]          wr_ptr_q;
  logic [AW-1:0]          rd_ptr_q;
  // Occupancy, 0 to DEPTH
  logic [CW-1:0]          count_q;
  logic                   full;
  logic                   push;
  logic                   pop;

  // Pointer step with wrap for any depth
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1)) begin
      return {AW{1'b0}};
    end
    return ptr + 1'b1;
  endfunction

  assign full        = (count_q == CW'(DEPTH));
  assign out_valid_o = (count_q != '0);
  assign out_beat_o  = mem_q[rd_ptr_q];
  // A pop frees a slot for a push in the same cycle
  assign in_ready_o  = !full || out_ready_i;
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clock) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_beat_i;
    end
  end

endmodule

`default_nettype wire

//--- ep_out/mmio_cmd_parser.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_cmd_parser (
  input  logic                   clock,
  input  logic                   rst_n_i,
  // Host byte stream
  input  logic                   usb_valid_i,
  output logic                   usb_ready_o,
  input  logic [7:0]             usb_data_i,
  input  logic                   usb_last_i,
  // Decoded command to the store unit
  output logic                   cmd_valid_o,
  input  logic                   cmd_ready_i,
  output mmio_pkg::mmio_cmd_t    cmd_o,
  // STORE payload into the packet FIFO
  output logic                   fifo_valid_o,
  input  logic                   fifo_ready_i,
  output mmio_pkg::stream_beat_t fifo_beat_o,
  // Command completed by the store unit
  input  logic                   done_i,
  input  logic                   clear_stall_i,
  output logic                   stalled_o
);

  // Frame states IDLE to IDOP, then command hand-off and data phase
  typedef enum logic [2:0] {
    IDLE,
    ADDR,
    WORD,
    IDOP,
    ISSUE,
    DATA,
    WAIT,
    HALT
  } state_e;

  state_e              state_q;
  // Byte position within the 11-byte frame
  logic [3:0]          pos_q;
  logic [31:0]         word_q;
  logic [31:0]         word_next;
  // STORE bytes still to forward
  logic [15:0]         rem_q;
  mmio_pkg::mmio_cmd_t cmd_q;
  logic                take;
  logic                in_frame;
  logic [7:0]          magic_byte;

  assign take      = usb_valid_i && usb_ready_o;
  assign in_frame  = (state_q == IDLE) || (state_q == ADDR) ||
                     (state_q == WORD) || (state_q == IDOP);
  // Little-endian, so new bytes enter at the top
  assign word_next = {usb_data_i, word_q[31:8]};
  // Magic is checked byte by byte
  assign magic_byte = mmio_pkg::MMIO_MAGIC[8*pos_q[1:0] +: 8];

  // Ready while parsing, FIFO space while forwarding, otherwise held off
  always_comb begin
    case (state_q)
      IDLE, ADDR, WORD, IDOP: usb_ready_o = 1'b1;
      DATA:                   usb_ready_o = fifo_ready_i;
      default:                usb_ready_o = 1'b0;
    endcase
  end

  assign cmd_valid_o  = (state_q == ISSUE);
  assign cmd_o        = cmd_q;
  assign stalled_o    = (state_q == HALT);
  // Payload bytes pass straight through to the FIFO
  assign fifo_valid_o = (state_q == DATA) && usb_valid_i;
  assign fifo_beat_o  = '{data: usb_data_i, last: (rem_q == 16'd1)};

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      pos_q   <= 4'd0;
    end else begin
      // Frame position restarts whenever no frame is open
      if (!in_frame) begin
        pos_q <= 4'd0;
      end else if (take) begin
        pos_q <= pos_q + 4'd1;
      end

      case (state_q)
        IDLE: begin
          if (take) begin
            if (usb_last_i || usb_data_i != magic_byte) begin
              state_q <= HALT;
            end else if (pos_q == 4'd3) begin
              state_q <= ADDR;
            end
          end
        end
        ADDR: begin
          // Early last is a short frame
          if (take) begin
            if (usb_last_i) begin
              state_q <= HALT;
            end else if (pos_q == 4'd7) begin
              state_q <= WORD;
            end
          end
        end
        WORD: begin
          if (take) begin
            if (usb_last_i) begin
              state_q <= HALT;
            end else if (pos_q == 4'd9) begin
              state_q <= IDOP;
            end
          end
        end
        IDOP: begin
          // Byte 11 must end the frame, reserved bits and opcodes rejected
          if (take) begin
            if (!usb_last_i || usb_data_i[3:2] != 2'b00 || usb_data_i[1]) begin
              state_q <= HALT;
            end else begin
              state_q <= ISSUE;
            end
          end
        end
        ISSUE: begin
          if (cmd_ready_i) begin
            if (cmd_q.op == mmio_pkg::OP_STORE && cmd_q.len != 16'd0) begin
              state_q <= DATA;
            end else begin
              state_q <= WAIT;
            end
          end
        end
        DATA: begin
          if (take && rem_q == 16'd1) begin
            state_q <= WAIT;
          end
        end
        WAIT: begin
          // One command in progress at a time
          if (done_i) begin
            state_q <= IDLE;
          end
        end
        HALT: begin
          if (clear_stall_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Frame fields and payload counter
  always_ff @(posedge clock) begin
    if (take && in_frame) begin
      word_q <= word_next;
    end
    if (take && state_q == ADDR && pos_q == 4'd7) begin
      cmd_q.lun  <= word_next[31:28];
      cmd_q.addr <= word_next[27:0];
    end
    if (take && state_q == WORD && pos_q == 4'd9) begin
      cmd_q.len <= {usb_data_i, word_q[31:24]};
    end
    if (take && state_q == IDOP) begin
      cmd_q.tag <= usb_data_i[7:4];
      cmd_q.op  <= mmio_pkg::mmio_op_e'(usb_data_i[1:0]);
    end
    // Loaded while the command waits, counted down per forwarded byte
    if (state_q == ISSUE) begin
      rem_q <= cmd_q.len;
    end else if (take && state_q == DATA) begin
      rem_q <= rem_q - 16'd1;
    end
  end

endmodule

`default_nettype wire

//--- common/mmio_pkg.sv
`default_nettype none

package mmio_pkg;

  // Opcode carried in bits 1:0 of the tag/opcode byte
  typedef enum logic [1:0] {
    OP_STORE = 2'd0,
    OP_SET   = 2'd1,
    // Reserved codes stall the end-point
    OP_RSVD2 = 2'd2,
    OP_RSVD3 = 2'd3
  } mmio_op_e;

  // Decoded command frame
  typedef struct packed {
    logic [3:0]  tag;
    mmio_op_e    op;
    logic [3:0]  lun;
    // Byte address in the register space
    logic [27:0] addr;
    // Byte count for STORE, value for SET
    logic [15:0] len;
  } mmio_cmd_t;

  // One payload byte on its way to the store unit
  typedef struct packed {
    logic [7:0] data;
    // Final byte of the STORE payload
    logic       last;
  } stream_beat_t;

  // Response to the host, one per completed command
  typedef struct packed {
    logic [3:0] tag;
    mmio_op_e   op;
  } mmio_resp_t;

  // Command magic "TART"
  // First byte received sits in bits 7:0
  localparam logic [31:0] MMIO_MAGIC = {8'h54, 8'h52, 8'h41, 8'h54};

endpackage

`default_nettype wire
